//--- verilog.f
+incdir+hdl
hdl/conv_num_pkg.sv
hdl/conv_stream_pkg.sv
hdl/line_ram.sv
hdl/conv_window.sv
hdl/conv_mac.sv
hdl/conv_output_stage.sv
hdl/conv2d_top.sv
dv/conv2d_tb_clock.sv
dv/conv2d_chk.sv
dv/conv2d_tb.sv

//--- Makefile
# Verilator build and run of the convolution testbench

VERILATOR ?= verilator
TOP       ?= conv2d_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/conv2d_tb.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv2d_tb import conv_num_pkg::*; import conv_stream_pkg::*; ();

    localparam int W = `CONV_IMG_WIDTH;
    localparam int K = `CONV_KERNEL_SIZE;
    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int FRAC = `CONV_FRAC_BITS;
    localparam int OUT_W = W - K + 1;
    localparam int BEATS = OUT_W * OUT_W;
    localparam int PERIOD_NS = 4;
    // Seven images over all tests with two in the last test
    localparam int TOTAL_PIXELS = 7 * W * W;
    localparam int TIMEOUT_NS = TOTAL_PIXELS * (2 * CH + 4) * PERIOD_NS * 4;
    localparam pixel_t ONE = pixel_t'(1 << FRAC);

    logic         clk;
    logic         reset;
    pixel_beat_t  in_pixel;
    logic         in_valid;
    logic         in_ready;
    kernel_set_t  weights;
    bias_vec_t    bias;
    result_beat_t out_result;
    logic         out_valid;
    logic         out_ready;

    // Stimulus state
    pixel_t       img [W * W];
    result_beat_t exp_q [$];
    string        test_name;
    logic [31:0]  rng;
    logic [31:0]  stall_rng;
    logic         stall_en;
    logic         gap_en;
    int           checks;
    int           errors;
    int           image_beats;

    conv2d_tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) u_clock (
        .o_clk   (clk),
        .o_reset (reset)
    );

    conv2d_top uut (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (in_pixel),
        .i_valid    (in_valid),
        .o_ready_in (in_ready),
        .i_weights  (weights),
        .i_bias     (bias),
        .o_result   (out_result),
        .o_valid    (out_valid),
        .i_ready    (out_ready)
    );

    bind conv2d_top conv2d_chk u_chk (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (i_pixel),
        .i_valid    (i_valid),
        .o_ready_in (o_ready_in),
        .o_result   (o_result),
        .o_valid    (o_valid),
        .i_ready    (i_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [95:0] expected,
                               input logic [95:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %h actual %h", what, expected, actual);
        end
    endtask

    // Reference model over row-major positions
    // Q15.16 products truncated by an arithmetic shift
    task automatic model_image();
        result_beat_t beat;
        product_t     prod;
        pixel_t       acc;
        for (int r = 0; r < OUT_W; r++) begin
            for (int c = 0; c < OUT_W; c++) begin
                beat.last = (r == OUT_W - 1) && (c == OUT_W - 1);
                for (int ch = 0; ch < CH; ch++) begin
                    acc = '0;
                    for (int kr = 0; kr < K; kr++) begin
                        for (int kc = 0; kc < K; kc++) begin
                            prod = product_t'(weights[ch][kr][kc]) *
                                   product_t'(img[(r + kr) * W + c + kc]);
                            acc = acc + pixel_t'(prod >>> FRAC);
                        end
                    end
                    acc = acc + bias[ch];
                    if ((`CONV_RELU != 0) && (acc < 0)) begin
                        acc = '0;
                    end
                    beat.data[ch] = acc;
                end
                exp_q.push_back(beat);
            end
        end
    endtask

    // Samples in about +-8.0
    task automatic fill_random_image();
        for (int i = 0; i < W * W; i++) begin
            rng = xorshift(rng);
            img[i] = pixel_t'(rng) >>> 12;
        end
    endtask

    // Weights in about +-2.0
    // All made non-positive on request
    task automatic randomize_weights(input logic negative);
        pixel_t w;
        for (int ch = 0; ch < CH; ch++) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    rng = xorshift(rng);
                    w = pixel_t'(rng) >>> 14;
                    if (negative && (w > 0)) begin
                        w = -w;
                    end
                    weights[ch][r][c] = w;
                end
            end
        end
    endtask

    task automatic randomize_bias();
        for (int ch = 0; ch < CH; ch++) begin
            rng = xorshift(rng);
            bias[ch] = pixel_t'(rng) >>> 12;
        end
    endtask

    // One image in row-major order
    // Valid held until each pixel is taken
    task automatic send_image();
        for (int i = 0; i < W * W; i++) begin
            if (gap_en) begin
                rng = xorshift(rng);
                while (rng[1:0] == 2'b00) begin
                    in_valid = 1'b0;
                    @(negedge clk);
                    rng = xorshift(rng);
                end
            end
            in_pixel.data = img[i];
            in_pixel.last = (i == W * W - 1);
            in_valid = 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_pixel.last = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Centre tap only
    // Expected beat is the window centre
    task automatic identity_kernel();
        result_beat_t beat;
        test_name = "identity";
        weights = '0;
        bias = '0;
        for (int ch = 0; ch < CH; ch++) begin
            weights[ch][K / 2][K / 2] = ONE;
        end
        for (int i = 0; i < W * W; i++) begin
            img[i] = pixel_t'(i + 1) <<< FRAC;
        end
        for (int r = 0; r < OUT_W; r++) begin
            for (int c = 0; c < OUT_W; c++) begin
                beat.last = (r == OUT_W - 1) && (c == OUT_W - 1);
                for (int ch = 0; ch < CH; ch++) begin
                    beat.data[ch] = img[(r + K / 2) * W + c + K / 2];
                end
                exp_q.push_back(beat);
            end
        end
        send_image();
        wait_drain();
    endtask

    task automatic random_stream(input string name, input logic stalls);
        test_name = name;
        stall_en = stalls;
        gap_en = stalls;
        fill_random_image();
        randomize_weights(1'b0);
        randomize_bias();
        model_image();
        send_image();
        wait_drain();
        stall_en = 1'b0;
        gap_en = 1'b0;
    endtask

    // Negative weights and a -0.5 bias give both clamped and positive results
    task automatic bias_relu_clamp();
        test_name = "bias_relu";
        fill_random_image();
        randomize_weights(1'b1);
        for (int ch = 0; ch < CH; ch++) begin
            bias[ch] = -(ONE >>> 1);
        end
        model_image();
        send_image();
        wait_drain();
    endtask

    // Second image follows the first with no idle cycle and no reset
    task automatic back_to_back_images();
        test_name = "back_to_back";
        randomize_weights(1'b0);
        randomize_bias();
        fill_random_image();
        model_image();
        send_image();
        fill_random_image();
        model_image();
        send_image();
        wait_drain();
    endtask

    // Output monitor compares every transferred beat in order
    always @(posedge clk) begin : monitor
        result_beat_t expected;
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output beat in test %s arrived with nothing expected", test_name);
            end else begin
                expected = exp_q.pop_front();
                check_value(test_name, 96'(expected), 96'(out_result));
            end
            image_beats++;
            if (out_result.last) begin
                check_value({test_name, " beats per image"}, 96'(BEATS), 96'(image_beats));
                image_beats = 0;
            end
        end
    end

    // Downstream ready with random stalls only when enabled
    initial begin
        out_ready = 1'b1;
        stall_rng = 32'he884_bd4c ^ 32'h5a5a_0f0f;
        forever begin
            @(negedge clk);
            stall_rng = xorshift(stall_rng);
            out_ready = !stall_en || (stall_rng[1:0] != 2'b00);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns with %0d beats still expected",
                 TIMEOUT_NS, exp_q.size());
        $display("sim failed");
        $finish;
    end

    initial begin
        in_pixel = '0;
        in_valid = 1'b0;
        weights = '0;
        bias = '0;
        rng = 32'he884_bd4c;
        stall_en = 1'b0;
        gap_en = 1'b0;
        checks = 0;
        errors = 0;
        image_beats = 0;
        test_name = "reset";
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        identity_kernel();
        random_stream("random_data", 1'b0);
        random_stream("last_flag", 1'b0);
        random_stream("back_pressure", 1'b1);
        bias_relu_clamp();
        back_to_back_images();
        // Room for any stray extra beat to show up
        repeat (20) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out", exp_q.size());
        end
        if (uut.u_chk.failures != 0) begin
            $display("%0d protocol assertions failed", uut.u_chk.failures);
        end
        $display("Checks %0d, errors %0d, assertion failures %0d, missing beats %0d",
                 checks, errors, uut.u_chk.failures, exp_q.size());
        if ((errors == 0) && (exp_q.size() == 0) && (uut.u_chk.failures == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- dv/conv2d_chk.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv2d_chk import conv_stream_pkg::*; (
    input logic         clk,
    input logic         reset,
    input pixel_beat_t  i_pixel,
    input logic         i_valid,
    input logic         o_ready_in,
    input result_beat_t o_result,
    input logic         o_valid,
    input logic         i_ready
);

    // Number of failed assertions so far
    int failures;

    initial begin
        failures = 0;
    end

    // Pixel beat held stable until the DUT takes it
    input_hold: assert property (@(posedge clk) disable iff (reset)
        (i_valid && !o_ready_in) |=> (i_valid && $stable(i_pixel)))
        else begin
            $error("Input pixel beat changed or dropped before transfer");
            failures++;
        end

    // Result beat held stable under back-pressure
    output_hold: assert property (@(posedge clk) disable iff (reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_result)))
        else begin
            $error("Output result beat changed or dropped before transfer");
            failures++;
        end

    // Output stage comes out of reset empty
    reset_empty: assert property (@(posedge clk)
        reset |=> !o_valid)
        else begin
            $error("Output valid high in the cycle after reset");
            failures++;
        end

    // Last only ever rides on a valid beat
    last_with_valid: assert property (@(posedge clk) disable iff (reset)
        o_result.last |-> o_valid)
        else begin
            $error("Output last flag high without output valid");
            failures++;
        end

endmodule

//--- dv/conv2d_tb_clock.sv
`timescale 1ns/1ps

module conv2d_tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset released on a falling edge, like all other stimulus
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

//--- hdl/conv2d_top.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv2d_top import conv_num_pkg::*; import conv_stream_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  pixel_beat_t  i_pixel,
    input  logic         i_valid,
    output logic         o_ready_in,
    input  kernel_set_t  i_weights,
    input  bias_vec_t    i_bias,
    output result_beat_t o_result,
    output logic         o_valid,
    input  logic         i_ready
);

    // Line buffer to MAC
    window_beat_t window;
    logic         window_valid;
    logic         window_ready;

    // MAC to output stage, no bias yet
    result_beat_t sum;
    logic         sum_valid;
    logic         sum_ready;

    conv_window u_window (
        .clk        (clk),
        .reset      (reset),
        .i_pixel    (i_pixel),
        .i_valid    (i_valid),
        .o_ready_in (o_ready_in),
        .o_window   (window),
        .o_valid    (window_valid),
        .i_ready    (window_ready)
    );

    conv_mac u_mac (
        .clk       (clk),
        .reset     (reset),
        .i_window  (window),
        .i_valid   (window_valid),
        .o_ready   (window_ready),
        .i_weights (i_weights),
        .o_sum     (sum),
        .o_valid   (sum_valid),
        .i_ready   (sum_ready)
    );

    conv_output_stage #(
        .RELU (`CONV_RELU)
    ) u_output_stage (
        .clk      (clk),
        .reset    (reset),
        .i_sum    (sum),
        .i_valid  (sum_valid),
        .o_ready  (sum_ready),
        .i_bias   (i_bias),
        .o_result (o_result),
        .o_valid  (o_valid),
        .i_ready  (i_ready)
    );

endmodule

//--- hdl/conv_output_stage.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_output_stage import conv_num_pkg::*; import conv_stream_pkg::*; #(
    parameter int RELU = 1
) (
    input  logic         clk,
    input  logic         reset,
    input  result_beat_t i_sum,
    input  logic         i_valid,
    output logic         o_ready,
    input  bias_vec_t    i_bias,
    output result_beat_t o_result,
    output logic         o_valid,
    input  logic         i_ready
);

    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int VB = `CONV_VALUE_BITS;

    pixel_t [CH-1:0] next_data;
    pixel_t [CH-1:0] data_q;
    logic            valid_q;
    logic            last_q;

    // Bias add wraps at 32 bits
    always_comb begin
        for (int ch = 0; ch < CH; ch++) begin
            next_data[ch] = i_sum.data[ch] + i_bias[ch];
            // Negative when the sign bit is set
            if ((RELU != 0) && next_data[ch][VB-1]) begin
                next_data[ch] = '0;
            end
        end
    end

    // Single entry, refills in the cycle it drains
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (i_valid && o_ready) begin
            valid_q <= 1'b1;
            last_q  <= i_sum.last;
        end else if (i_ready) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            data_q <= next_data;
        end
    end

    assign o_result.data = data_q;
    assign o_result.last = last_q;
    assign o_valid       = valid_q;

endmodule

//--- hdl/conv_mac.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_mac import conv_num_pkg::*; import conv_stream_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  window_beat_t i_window,
    input  logic         i_valid,
    output logic         o_ready,
    input  kernel_set_t  i_weights,
    output result_beat_t o_sum,
    output logic         o_valid,
    input  logic         i_ready
);

    localparam int K = `CONV_KERNEL_SIZE;
    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int FRAC = `CONV_FRAC_BITS;
    localparam int VB = `CONV_VALUE_BITS;
    localparam int NTAPS = K * K;
    localparam int CH_BITS = (CH > 1) ? $clog2(CH) : 1;
    localparam logic [CH_BITS-1:0] LAST_CH = CH_BITS'(CH - 1);

    // Latched window
    kernel_t              taps_q;
    logic                 last_q;
    product_t             prod_q [NTAPS];
    pixel_t [CH-1:0]      sum_q;
    pixel_t               acc;

    // Sequencer state
    logic                 run_q;
    logic                 phase_q;
    logic                 fin_q;
    logic                 valid_q;
    logic [CH_BITS-1:0]   ch_q;
    logic                 win_accept;

    // Busy from window accept until the result leaves
    assign o_ready    = !(run_q || fin_q || valid_q);
    assign win_accept = i_valid && o_ready;

    // Phase 0 multiplies, phase 1 sums, then the next channel
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q   <= 1'b0;
            phase_q <= 1'b0;
            fin_q   <= 1'b0;
            valid_q <= 1'b0;
            ch_q    <= '0;
            last_q  <= 1'b0;
        end else begin
            fin_q <= 1'b0;
            if (win_accept) begin
                run_q   <= 1'b1;
                phase_q <= 1'b0;
                ch_q    <= '0;
                last_q  <= i_window.last;
            end else if (run_q) begin
                phase_q <= !phase_q;
                if (phase_q) begin
                    if (ch_q == LAST_CH) begin
                        run_q <= 1'b0;
                        fin_q <= 1'b1;
                        ch_q  <= '0;
                    end else begin
                        ch_q <= ch_q + CH_BITS'(1);
                    end
                end
            end
            // Extra cycle after the last sum raises valid
            if (fin_q) begin
                valid_q <= 1'b1;
            end else if (valid_q && i_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Keep the Q15.16 middle of each product, sum wraps at 32 bits
    always_comb begin
        acc = '0;
        for (int i = 0; i < NTAPS; i++) begin
            acc = acc + pixel_t'(prod_q[i][FRAC +: VB]);
        end
    end

    always_ff @(posedge clk) begin
        if (win_accept) begin
            taps_q <= i_window.taps;
        end
        // All kernel products of one channel at once
        if (run_q && !phase_q) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    prod_q[r*K + c] <= product_t'(i_weights[ch_q][r][c]) *
                                       product_t'(taps_q[r][c]);
                end
            end
        end
        if (run_q && phase_q) begin
            sum_q[ch_q] <= acc;
        end
    end

    assign o_sum.data = sum_q;
    assign o_sum.last = last_q;
    assign o_valid    = valid_q;

endmodule

//--- hdl/conv_window.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_window import conv_num_pkg::*; import conv_stream_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  pixel_beat_t  i_pixel,
    input  logic         i_valid,
    output logic         o_ready_in,
    output window_beat_t o_window,
    output logic         o_valid,
    input  logic         i_ready
);

    localparam int W = `CONV_IMG_WIDTH;
    localparam int K = `CONV_KERNEL_SIZE;
    // Newest kernel row comes straight from the input
    localparam int BUF_ROWS = K - 1;
    localparam int ADDR_BITS = $clog2(W);
    localparam int SEL_BITS = (BUF_ROWS > 1) ? $clog2(BUF_ROWS) : 1;
    localparam logic [ADDR_BITS-1:0] LAST_IDX = ADDR_BITS'(W - 1);
    localparam logic [ADDR_BITS-1:0] FIRST_FULL = ADDR_BITS'(K - 1);
    localparam logic [SEL_BITS-1:0] LAST_SEL = SEL_BITS'(BUF_ROWS - 1);

    // Position of the next pixel
    logic [ADDR_BITS-1:0] col_q;
    logic [ADDR_BITS-1:0] row_q;
    logic [ADDR_BITS-1:0] col_next;
    // RAM that takes the current row, it holds the oldest buffered row
    logic [SEL_BITS-1:0]  wr_sel_q;
    logic [ADDR_BITS-1:0] ram_r_addr;
    pixel_t               ram_rd [BUF_ROWS];

    // Column entering the window, oldest row first
    pixel_t               col_in [K];
    kernel_t              taps_q;
    logic                 win_valid_q;
    logic                 win_last_q;

    logic                 pix_accept;
    logic                 row_end;
    logic                 img_end;
    logic                 win_done;

    // Stall input only while a window waits downstream
    assign o_ready_in = !win_valid_q || i_ready;
    assign pix_accept = i_valid && o_ready_in;

    assign row_end = (col_q == LAST_IDX);
    assign img_end = i_pixel.last || (row_end && (row_q == LAST_IDX));
    // Pixel closes a full kernel position
    assign win_done = (row_q >= FIRST_FULL) && (col_q >= FIRST_FULL);

    always_comb begin
        if (row_end || img_end) begin
            col_next = '0;
        end else begin
            col_next = col_q + ADDR_BITS'(1);
        end
    end

    // Read one column ahead so the RAM word is ready for the next pixel
    assign ram_r_addr = pix_accept ? col_next : col_q;

    genvar g;
    generate
        for (g = 0; g < BUF_ROWS; g++) begin : g_rows
            line_ram u_line_ram (
                .clk      (clk),
                .i_w_en   (pix_accept && (wr_sel_q == SEL_BITS'(g))),
                .i_w_addr (col_q),
                .i_w_data (i_pixel.data),
                .i_r_addr (ram_r_addr),
                .o_r_data (ram_rd[g])
            );
        end
    endgenerate

    // Rotate the RAM outputs so that tap row 0 is the oldest image row
    always_comb begin
        int idx;
        for (int i = 0; i < BUF_ROWS; i++) begin
            idx = int'(wr_sel_q) + i;
            if (idx >= BUF_ROWS) begin
                idx = idx - BUF_ROWS;
            end
            col_in[i] = ram_rd[idx];
        end
        col_in[K-1] = i_pixel.data;
    end

    // Row and column tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            col_q    <= '0;
            row_q    <= '0;
            wr_sel_q <= '0;
        end else if (pix_accept) begin
            col_q <= col_next;
            if (img_end) begin
                row_q    <= '0;
                wr_sel_q <= '0;
            end else if (row_end) begin
                row_q    <= row_q + ADDR_BITS'(1);
                wr_sel_q <= (wr_sel_q == LAST_SEL) ? '0 : wr_sel_q + SEL_BITS'(1);
            end
        end
    end

    // Window shift registers
    // Newest column enters on the right
    always_ff @(posedge clk) begin
        if (pix_accept) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    taps_q[r][c] <= taps_q[r][c+1];
                end
                taps_q[r][K-1] <= col_in[r];
            end
        end
    end

    // One window beat pending at most
    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid_q <= 1'b0;
            win_last_q  <= 1'b0;
        end else if (pix_accept && win_done) begin
            win_valid_q <= 1'b1;
            win_last_q  <= i_pixel.last;
        end else if (i_ready) begin
            win_valid_q <= 1'b0;
            win_last_q  <= 1'b0;
        end
    end

    // Taps stay put while the beat is pending
    assign o_window.taps = taps_q;
    assign o_window.last = win_last_q;
    assign o_valid       = win_valid_q;

endmodule

//--- hdl/line_ram.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module line_ram import conv_num_pkg::*; (
    input  logic                               clk,
    input  logic                               i_w_en,
    input  logic [$clog2(`CONV_IMG_WIDTH)-1:0] i_w_addr,
    input  pixel_t                             i_w_data,
    input  logic [$clog2(`CONV_IMG_WIDTH)-1:0] i_r_addr,
    output pixel_t                             o_r_data
);

    // One image row of samples
    pixel_t mem [`CONV_IMG_WIDTH];

    // Read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        if (i_w_en) begin
            mem[i_w_addr] <= i_w_data;
        end
        o_r_data <= mem[i_r_addr];
    end

endmodule

//--- hdl/conv_stream_pkg.sv
`include "conv_config.svh"

package conv_stream_pkg;

    import conv_num_pkg::*;

    // Input pixel beat
    typedef struct packed {
        pixel_t data;
        logic   last;
    } pixel_beat_t;

    // Full kernel window from the line buffer
    // Last marks the window holding the final pixel of the image
    typedef struct packed {
        kernel_t taps;
        logic    last;
    } window_beat_t;

    // All output channels of one kernel position
    typedef struct packed {
        pixel_t [`CONV_OUT_CHANNELS-1:0] data;
        logic                            last;
    } result_beat_t;

endpackage

//--- hdl/conv_num_pkg.sv
`include "conv_config.svh"

package conv_num_pkg;

    // One signed Q15.16 sample
    typedef logic signed [`CONV_VALUE_BITS-1:0] pixel_t;

    // Full product of two samples
    // Result keeps 2x fraction bits
    typedef logic signed [2*`CONV_VALUE_BITS-1:0] product_t;

    // Kernel taps for one output channel
    // First index is the row, second the column
    typedef pixel_t [`CONV_KERNEL_SIZE-1:0][`CONV_KERNEL_SIZE-1:0] kernel_t;

    // One kernel per output channel
    typedef kernel_t [`CONV_OUT_CHANNELS-1:0] kernel_set_t;

    // One bias per output channel
    typedef pixel_t [`CONV_OUT_CHANNELS-1:0] bias_vec_t;

endpackage

//--- hdl/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Pixels per row and rows per image, the image is square
`define CONV_IMG_WIDTH 8

// Side length of the square kernel
`define CONV_KERNEL_SIZE 3

// Output channels computed from the single input channel
`define CONV_OUT_CHANNELS 2

// Q15.16 sample format
`define CONV_FRAC_BITS 16
`define CONV_VALUE_BITS 32

// Set to 1 to clamp negative results to zero
`define CONV_RELU 1

`endif
